/* chart_if.sv */
`timescale 1ns/1ps

// Decoded chart events, reader to judge
interface chart_if;

	// Single-cycle strobe per step row
	logic step_valid;
	// Lanes marked by that row
	rhythm_game_pkg::lane_vec_t arrows;
	// Single-cycle strobe on END
	logic chart_end;
	// Level from start to END
	logic playing;

	modport reader (
		output step_valid,
		output arrows,
		output chart_end,
		output playing
	);

	modport judge (
		input step_valid,
		input arrows,
		input chart_end,
		input playing
	);

endinterface

/* chart_reader.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module chart_reader (
	input  logic                         Clk,
	input  logic                         rst_n,
	input  logic                         start,
	input  rhythm_game_pkg::chart_word_u sram_dq,
	output logic [`SRAM_ADDR_W-1:0]      sram_addr,
	output logic                         sram_oe_n,
	chart_if.reader                      ev
);

	localparam int TICK_W = $clog2(`CHART_TICK_DIV);

	logic [TICK_W-1:0] tick_cnt;
	logic tick;
	logic playing;
	logic word_vld;
	logic step_valid;
	logic chart_end;
	rhythm_game_pkg::chart_word_u word_q;
	rhythm_game_pkg::lane_vec_t arrows;

	// Last count of the divider while the chart runs
	assign tick = playing && (tick_cnt == TICK_W'(`CHART_TICK_DIV - 1));

	// ====================
	// Tick divider and read strobe
	// ====================
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt  <= '0;
			sram_oe_n <= 1'b1;
			word_vld  <= 1'b0;
		end else begin
			// OE low for the single cycle after a tick
			sram_oe_n <= ~tick;
			// Word sits in word_q the cycle after OE
			word_vld  <= ~sram_oe_n;
			if (start && !playing)
				tick_cnt <= '0;
			else if (tick)
				tick_cnt <= '0;
			else if (playing)
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Capture at the end of the OE cycle
	always_ff @(posedge Clk) begin
		if (!sram_oe_n)
			word_q <= sram_dq;
		if (word_vld)
			arrows <= word_q.step.arrows;
	end

	// ====================
	// Word decode and play state
	// ====================
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			playing    <= 1'b0;
			sram_addr  <= '0;
			step_valid <= 1'b0;
			chart_end  <= 1'b0;
		end else begin
			step_valid <= 1'b0;
			chart_end  <= 1'b0;
			if (start && !playing) begin
				// Restart from the top of the chart
				playing   <= 1'b1;
				sram_addr <= '0;
			end else if (word_vld) begin
				if (!word_q.step.is_ctrl) begin
					// Empty rows still strobe
					step_valid <= 1'b1;
					sram_addr  <= sram_addr + 1'b1;
				end else if (word_q.ctrl.op == rhythm_game_pkg::END) begin
					// Address parks on the END word
					chart_end <= 1'b1;
					playing   <= 1'b0;
				end else
					sram_addr <= sram_addr + 1'b1;
			end
		end
	end

	assign ev.step_valid = step_valid;
	assign ev.arrows     = arrows;
	assign ev.chart_end  = chart_end;
	assign ev.playing    = playing;

endmodule

/* lane_judge.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module lane_judge (
	input  logic                       Clk,
	input  logic                       rst_n,
	input  logic                       start,
	chart_if.judge                     ev,
	input  rhythm_game_pkg::lane_vec_t press,
	output rhythm_game_pkg::lane_vec_t hit,
	output rhythm_game_pkg::lane_vec_t miss,
	output logic                       done
);

	localparam int WIN_W = $clog2(`JUDGE_WINDOW + 1);

	// Cycles left in each lane's window, zero when closed
	logic [WIN_W-1:0] win_cnt [`LANES];
	rhythm_game_pkg::lane_vec_t open;
	logic chart_seen;

	always_comb begin
		for (int i = 0; i < `LANES; i++)
			open[i] = (win_cnt[i] != '0);
	end

	// ====================
	// Windows and verdicts
	// ====================
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LANES; i++)
				win_cnt[i] <= '0;
			hit        <= '0;
			miss       <= '0;
			chart_seen <= 1'b0;
			done       <= 1'b0;
		end else begin
			hit  <= '0;
			miss <= '0;
			if (start && !ev.playing) begin
				// New run, forget the old chart
				for (int i = 0; i < `LANES; i++)
					win_cnt[i] <= '0;
				chart_seen <= 1'b0;
				done       <= 1'b0;
			end else begin
				for (int i = 0; i < `LANES; i++) begin
					if (ev.step_valid && ev.arrows[i]) begin
						// A window still open here is overtaken
						miss[i]    <= open[i];
						win_cnt[i] <= WIN_W'(`JUDGE_WINDOW);
					end else if (open[i]) begin
						if (press[i] && ev.playing) begin
							hit[i]     <= 1'b1;
							win_cnt[i] <= '0;
						end else begin
							win_cnt[i] <= win_cnt[i] - 1'b1;
							// Last cycle of the window
							if (win_cnt[i] == WIN_W'(1))
								miss[i] <= 1'b1;
						end
					end
				end
				if (ev.chart_end)
					chart_seen <= 1'b1;
				// Sticky until the next start
				if (chart_seen && open == '0)
					done <= 1'b1;
			end
		end
	end

endmodule

/* lane_keys.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module lane_keys (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  rhythm_game_pkg::scan_code_t code,
	input  logic                        code_valid,
	output rhythm_game_pkg::lane_vec_t  press
);

	// Make code per lane, lane 0 first
	localparam rhythm_game_pkg::scan_code_t lane_code [`LANES] = '{
		`SCAN_LANE0, `SCAN_LANE1, `SCAN_LANE2, `SCAN_LANE3
	};

	logic brk_pend;
	logic ext_pend;
	rhythm_game_pkg::lane_vec_t held;
	rhythm_game_pkg::lane_vec_t lane_sel;

	// One-hot lane of the current byte, zero if unmapped
	always_comb begin
		lane_sel = '0;
		for (int i = 0; i < `LANES; i++)
			lane_sel[i] = (code == lane_code[i]);
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			brk_pend <= 1'b0;
			ext_pend <= 1'b0;
			held     <= '0;
			press    <= '0;
		end else begin
			press <= '0;
			if (code_valid) begin
				if (code == `SCAN_BREAK)
					brk_pend <= 1'b1;
				else if (code == `SCAN_EXT)
					ext_pend <= 1'b1;
				else begin
					// Any other byte ends the prefix sequence
					brk_pend <= 1'b0;
					ext_pend <= 1'b0;
					if (ext_pend) begin
						// Extended keys never map to a lane
					end else if (brk_pend)
						held <= held & ~lane_sel;
					else begin
						// Typematic repeat of a held key is dropped
						press <= lane_sel & ~held;
						held  <= held | lane_sel;
					end
				end
			end
		end
	end

endmodule

/* ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  logic                        ps2_clk,
	input  logic                        ps2_data,
	output rhythm_game_pkg::scan_code_t code,
	output logic                        code_valid
);

	// Two sync stages plus one history stage for edge detect
	logic [2:0] clk_sync;
	logic [1:0] data_sync;
	logic fall;
	logic [3:0] bit_cnt;
	logic [10:0] frame_q;
	logic [10:0] frame_next;
	logic frame_ok;

	assign fall = clk_sync[2] & ~clk_sync[1];

	// Bits arrive LSB first, so shift in from the top
	assign frame_next = {data_sync[1], frame_q[10:1]};

	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame_next[0] & frame_next[10] & (^frame_next[9:1]);

	// ====================
	// Sync and bit counter
	// ====================
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			// Idle lines float high
			clk_sync   <= '1;
			data_sync  <= '1;
			bit_cnt    <= '0;
			code_valid <= 1'b0;
		end else begin
			clk_sync   <= {clk_sync[1:0], ps2_clk};
			data_sync  <= {data_sync[0], ps2_data};
			code_valid <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					// Stop bit sampled, frame complete
					bit_cnt    <= '0;
					code_valid <= frame_ok;
				end else if (bit_cnt != 4'd0 || !data_sync[1])
					// Wait for a low start bit before counting
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Frame shifter and output byte
	always_ff @(posedge Clk) begin
		if (fall)
			frame_q <= frame_next;
		if (fall && bit_cnt == 4'd10)
			code <= frame_next[8:1];
	end

endmodule

/* rhythm_game.f */
+incdir+.
rhythm_game_pkg.sv
chart_if.sv
chart_reader.sv
ps2_rx.sv
lane_keys.sv
lane_judge.sv
score_display.sv
rhythm_game.sv
rhythm_game_tb.sv

/* rhythm_game.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module rhythm_game (
	input  logic                    Clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    ps2_clk,
	input  logic                    ps2_data,
	input  logic [`SRAM_DATA_W-1:0] sram_dq,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output logic                    sram_oe_n,
	output logic                    done,
	output logic [6:0]              hex0,
	output logic [6:0]              hex1,
	output logic [6:0]              hex2,
	output logic [6:0]              hex3,
	output logic [6:0]              hex4,
	output logic [6:0]              hex5
);

	rhythm_game_pkg::scan_code_t code;
	logic code_valid;
	rhythm_game_pkg::lane_vec_t press;
	rhythm_game_pkg::lane_vec_t hit;
	rhythm_game_pkg::lane_vec_t miss;

	// Chart events into the judge
	chart_if ev_if ();

	// ====================
	// Chart path
	// ====================
	chart_reader chart_reader_i (
		.Clk       (Clk),
		.rst_n     (rst_n),
		.start     (start),
		.sram_dq   (sram_dq),
		.sram_addr (sram_addr),
		.sram_oe_n (sram_oe_n),
		.ev        (ev_if.reader)
	);

	// ====================
	// Key path
	// ====================
	ps2_rx ps2_rx_i (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.code       (code),
		.code_valid (code_valid)
	);

	lane_keys lane_keys_i (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.code       (code),
		.code_valid (code_valid),
		.press      (press)
	);

	// Both paths meet here
	lane_judge lane_judge_i (
		.Clk   (Clk),
		.rst_n (rst_n),
		.start (start),
		.ev    (ev_if.judge),
		.press (press),
		.hit   (hit),
		.miss  (miss),
		.done  (done)
	);

	score_display score_display_i (
		.Clk   (Clk),
		.rst_n (rst_n),
		.start (start),
		.hit   (hit),
		.miss  (miss),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3),
		.hex4  (hex4),
		.hex5  (hex5)
	);

endmodule

/* rhythm_game_macros.svh */
`ifndef RHYTHM_GAME_MACROS_SVH
`define RHYTHM_GAME_MACROS_SVH

// ====================
// Geometry
// ====================
// One lane per playable key
`define LANES 4
// External chart SRAM
`define SRAM_ADDR_W 20
`define SRAM_DATA_W 16

// ====================
// Timing in clock cycles
// ====================
// Spacing of chart rows
`define CHART_TICK_DIV 2000
// How long a lane waits for its key
`define JUDGE_WINDOW 1500

// ====================
// Set-2 scan codes
// ====================
// Make codes for D, F, J, K
`define SCAN_LANE0 8'h23
`define SCAN_LANE1 8'h2B
`define SCAN_LANE2 8'h3B
`define SCAN_LANE3 8'h42
// Prefixes
`define SCAN_BREAK 8'hF0
`define SCAN_EXT 8'hE0

`endif

/* rhythm_game_pkg.sv */
`include "rhythm_game_macros.svh"

package rhythm_game_pkg;

	// One flag per lane
	typedef logic [`LANES-1:0] lane_vec_t;

	// Raw keyboard byte
	typedef logic [7:0] scan_code_t;

	// Score and miss counters
	typedef logic [15:0] score_t;

	// Segments g..a, lit when low
	typedef logic [6:0] seg7_t;

	// Control opcodes, anything but END is a no-op
	typedef enum logic [2:0] {
		END = 3'd0
	} chart_op_e;

	// Step row, top bit clear
	typedef struct packed {
		logic      is_ctrl;
		logic [10:0] spare;
		lane_vec_t arrows;
	} chart_step_t;

	// Control word, top bit set
	typedef struct packed {
		logic        is_ctrl;
		chart_op_e   op;
		logic [11:0] arg;
	} chart_ctrl_t;

	// Same 16 bits seen either way, is_ctrl picks the view
	typedef union packed {
		chart_step_t step;
		chart_ctrl_t ctrl;
	} chart_word_u;

endpackage

/* rhythm_game_tb.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module rhythm_game_tb;

	localparam int MEM_DEPTH = 64;
	// Tick periods spanned by all tests, plus slack for reset and done waits
	localparam int RUN_TICKS = 27;
	localparam longint WATCHDOG_NS = longint'(RUN_TICKS + 10) * `CHART_TICK_DIV * 10;
	localparam int READ_LIMIT = 3 * `CHART_TICK_DIV;

	// Active-low digits 0..F, segments g..a
	localparam rhythm_game_pkg::seg7_t seg_table [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};
	localparam rhythm_game_pkg::scan_code_t lane_scan [`LANES] = '{
		`SCAN_LANE0, `SCAN_LANE1, `SCAN_LANE2, `SCAN_LANE3
	};

	logic Clk;
	logic rst_n;
	logic start;
	logic ps2_clk;
	logic ps2_data;
	logic [`SRAM_DATA_W-1:0] sram_dq;
	logic [`SRAM_ADDR_W-1:0] sram_addr;
	logic sram_oe_n;
	logic done;
	rhythm_game_pkg::seg7_t hex0, hex1, hex2, hex3, hex4, hex5;

	rhythm_game_pkg::chart_word_u sram_mem [MEM_DEPTH];
	logic [31:0] rng_state;
	int err_count;
	int tests_passed;
	int tests_failed;

	rhythm_game rhythm_game_i (
		.Clk(Clk), .rst_n(rst_n), .start(start), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.sram_dq(sram_dq), .sram_addr(sram_addr), .sram_oe_n(sram_oe_n), .done(done),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	always #5 Clk = ~Clk;

	// ====================
	// Chart SRAM model
	// ====================
	function automatic rhythm_game_pkg::chart_word_u step_word(
		input rhythm_game_pkg::lane_vec_t lanes);
		rhythm_game_pkg::chart_word_u w;
		w.step.is_ctrl = 1'b0;
		w.step.spare   = '0;
		w.step.arrows  = lanes;
		return w;
	endfunction

	// END word, ignored arg carries the address
	function automatic rhythm_game_pkg::chart_word_u end_word(input logic [19:0] addr);
		rhythm_game_pkg::chart_word_u w;
		w.ctrl.is_ctrl = 1'b1;
		w.ctrl.op      = rhythm_game_pkg::END;
		w.ctrl.arg     = addr[11:0] ^ {4'h0, addr[19:12]};
		return w;
	endfunction

	// Driven only while OE is low
	assign sram_dq = sram_oe_n ? 'z :
		(sram_addr < MEM_DEPTH) ? 16'(sram_mem[sram_addr[5:0]]) : 16'(end_word(sram_addr));

	// LCG for arrow patterns
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Digit pattern back to a nibble, -1 if not a hex digit
	function automatic int seg_to_nib(input rhythm_game_pkg::seg7_t s);
		for (int i = 0; i < 16; i++)
			if (s === seg_table[i])
				return i;
		return -1;
	endfunction

	// ====================
	// Compare tasks
	// ====================
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_count++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_seg(input string name, input rhythm_game_pkg::seg7_t got,
		input rhythm_game_pkg::seg7_t exp);
		if (got !== exp) begin
			err_count++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input logic [`SRAM_ADDR_W-1:0] exp);
		if (sram_addr !== exp) begin
			err_count++;
			$display("Error sram_addr: got %h, expected %h", sram_addr, exp);
		end
	endtask

	// Score read back from hex3..hex0
	task automatic check_score(input rhythm_game_pkg::score_t exp);
		rhythm_game_pkg::seg7_t digs [4];
		rhythm_game_pkg::score_t got;
		int n;
		bit ok;
		digs = '{hex0, hex1, hex2, hex3};
		got = '0;
		ok = 1'b1;
		for (int i = 0; i < 4; i++) begin
			n = seg_to_nib(digs[i]);
			if (n < 0)
				ok = 1'b0;
			else
				got[i*4 +: 4] = n[3:0];
		end
		if (!ok) begin
			err_count++;
			$display("A score digit shows a pattern that is no hex digit");
		end else if (got !== exp) begin
			err_count++;
			$display("Error score: got %h, expected %h", got, exp);
		end
	endtask

	// Miss count low byte on hex5..hex4
	task automatic check_misses(input int exp);
		check_seg("hex4", hex4, seg_table[exp % 16]);
		check_seg("hex5", hex5, seg_table[(exp / 16) % 16]);
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (err_count == err_before) begin
			tests_passed++;
			$display("PASS  %s", name);
		end else begin
			tests_failed++;
			$display("FAIL  %s", name);
		end
	endtask

	// ====================
	// Stimulus helpers
	// ====================
	// One frame at 80 ns per bit, then a short idle gap
	task automatic send_byte(input rhythm_game_pkg::scan_code_t b, input bit bad_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data <= frame[i];
			repeat (4) @(posedge Clk);
			ps2_clk <= 1'b0;
			repeat (4) @(posedge Clk);
			ps2_clk <= 1'b1;
		end
		ps2_data <= 1'b1;
		repeat (8) @(posedge Clk);
	endtask

	// Makes first so every press lands early in the window
	task automatic press_lanes(input rhythm_game_pkg::lane_vec_t lanes);
		for (int i = 0; i < `LANES; i++)
			if (lanes[i])
				send_byte(lane_scan[i], 1'b0);
		for (int i = 0; i < `LANES; i++)
			if (lanes[i]) begin
				send_byte(`SCAN_BREAK, 1'b0);
				send_byte(lane_scan[i], 1'b0);
			end
	endtask

	task automatic pulse_start();
		start <= 1'b1;
		@(posedge Clk);
		start <= 1'b0;
	endtask

	// Next OE strobe, then its address
	task automatic wait_read(input int exp_addr);
		int n;
		n = 0;
		do begin
			@(posedge Clk);
			n++;
		end while (sram_oe_n && n < READ_LIMIT);
		if (sram_oe_n) begin
			err_count++;
			$display("No SRAM read strobe within %0d cycles", READ_LIMIT);
		end else
			check_addr(exp_addr);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (done !== 1'b1 && n < `JUDGE_WINDOW + 2 * `CHART_TICK_DIV) begin
			@(posedge Clk);
			n++;
		end
		if (done !== 1'b1) begin
			err_count++;
			$display("done never rose after the END word");
		end
		repeat (2) @(posedge Clk);
	endtask

	// Eight random rows plus END, optionally hit every marked lane
	task automatic play_chart(input bit with_keys, output int marked);
		rhythm_game_pkg::lane_vec_t rows [8];
		marked = 0;
		for (int k = 0; k < 8; k++) begin
			rows[k] = rhythm_game_pkg::lane_vec_t'(next_rand() >> 16);
			if (rows[k] == '0)
				rows[k] = 4'b1000;
			marked += $countones(rows[k]);
			sram_mem[k] = step_word(rows[k]);
		end
		sram_mem[8] = end_word(20'd8);
		pulse_start();
		for (int k = 0; k < 9; k++) begin
			wait_read(k);
			// No verdict on the chart before its END word
			check_bit("done", done, 1'b0);
			if (k < 8 && with_keys)
				press_lanes(rows[k]);
		end
		wait_done();
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset();
		int e;
		e = err_count;
		check_bit("sram_oe_n", sram_oe_n, 1'b1);
		check_bit("done", done, 1'b0);
		check_seg("hex0", hex0, seg_table[0]);
		check_seg("hex1", hex1, seg_table[0]);
		check_seg("hex2", hex2, seg_table[0]);
		check_seg("hex3", hex3, seg_table[0]);
		check_misses(0);
		finish_test("reset state", e);
	endtask

	task automatic test_full_hits();
		int e;
		int marked;
		e = err_count;
		play_chart(1'b1, marked);
		check_score(rhythm_game_pkg::score_t'(marked));
		check_misses(0);
		finish_test("every marked lane hit", e);
	endtask

	task automatic test_all_misses();
		int e;
		int marked;
		e = err_count;
		play_chart(1'b0, marked);
		check_score('0);
		check_misses(marked);
		finish_test("no presses, all missed", e);
	endtask

	// Lane 2, then all four lanes, then END
	task automatic test_key_noise();
		int e;
		e = err_count;
		sram_mem[0] = step_word(4'b0100);
		sram_mem[1] = step_word(4'b1111);
		sram_mem[2] = end_word(20'd2);
		pulse_start();
		wait_read(0);
		// Closed lane, then the one real hit
		send_byte(`SCAN_LANE0, 1'b0);
		send_byte(`SCAN_LANE2, 1'b0);
		send_byte(`SCAN_BREAK, 1'b0);
		send_byte(`SCAN_LANE0, 1'b0);
		wait_read(1);
		// Repeat without break, bad parity, extended prefix, unmapped key
		send_byte(`SCAN_LANE2, 1'b0);
		send_byte(`SCAN_LANE3, 1'b1);
		send_byte(`SCAN_EXT, 1'b0);
		send_byte(`SCAN_LANE3, 1'b0);
		send_byte(8'h1C, 1'b0);
		send_byte(`SCAN_BREAK, 1'b0);
		send_byte(8'h1C, 1'b0);
		wait_read(2);
		wait_done();
		send_byte(`SCAN_BREAK, 1'b0);
		send_byte(`SCAN_LANE2, 1'b0);
		check_score(16'd1);
		check_misses(4);
		finish_test("key noise ignored", e);
	endtask

	// Follows the noise test, counters hold 1 and 4
	task automatic test_restart();
		int e;
		int oe_seen;
		e = err_count;
		oe_seen = 0;
		check_bit("done", done, 1'b1);
		repeat (2 * `CHART_TICK_DIV) begin
			@(posedge Clk);
			if (!sram_oe_n)
				oe_seen++;
		end
		if (oe_seen != 0) begin
			err_count++;
			$display("SRAM was read %0d times after the END word", oe_seen);
		end
		pulse_start();
		@(posedge Clk);
		check_bit("done", done, 1'b0);
		check_score('0);
		check_misses(0);
		wait_read(0);
		finish_test("restart after END", e);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		Clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		rng_state = 32'hdcf2_f384;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < MEM_DEPTH; i++)
			sram_mem[i] = end_word(20'(i));
		repeat (16) @(posedge Clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge Clk);
		test_reset();
		test_full_hits();
		test_all_misses();
		test_key_noise();
		test_restart();
		$display("Tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests completed");
		$display("Test failures found");
		$finish;
	end

endmodule

/* score_display.sv */
`timescale 1ns/1ps
`include "rhythm_game_macros.svh"

module score_display (
	input  logic                       Clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  rhythm_game_pkg::lane_vec_t hit,
	input  rhythm_game_pkg::lane_vec_t miss,
	output rhythm_game_pkg::seg7_t     hex0,
	output rhythm_game_pkg::seg7_t     hex1,
	output rhythm_game_pkg::seg7_t     hex2,
	output rhythm_game_pkg::seg7_t     hex3,
	output rhythm_game_pkg::seg7_t     hex4,
	output rhythm_game_pkg::seg7_t     hex5
);

	localparam int CNT_W = $clog2(`LANES + 1);

	rhythm_game_pkg::score_t score;
	rhythm_game_pkg::score_t misses;
	rhythm_game_pkg::score_t score_nxt;
	rhythm_game_pkg::score_t misses_nxt;

	// Number of lanes set in a pulse vector
	function automatic logic [CNT_W-1:0] lane_count(input rhythm_game_pkg::lane_vec_t v);
		logic [CNT_W-1:0] n;
		n = '0;
		for (int i = 0; i < `LANES; i++)
			n = n + CNT_W'(v[i]);
		return n;
	endfunction

	// Stops at FFFF
	function automatic rhythm_game_pkg::score_t sat_add(input rhythm_game_pkg::score_t a,
		input logic [CNT_W-1:0] b);
		logic [16:0] sum;
		sum = {1'b0, a} + 17'(b);
		return sum[16] ? 16'hFFFF : sum[15:0];
	endfunction

	// Hex digit to active-low segments
	function automatic rhythm_game_pkg::seg7_t hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	// Next values feed the segments directly, one cycle after the pulse
	assign score_nxt  = start ? '0 : sat_add(score, lane_count(hit));
	assign misses_nxt = start ? '0 : sat_add(misses, lane_count(miss));

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			score  <= '0;
			misses <= '0;
			hex0   <= hex_seg(4'h0);
			hex1   <= hex_seg(4'h0);
			hex2   <= hex_seg(4'h0);
			hex3   <= hex_seg(4'h0);
			hex4   <= hex_seg(4'h0);
			hex5   <= hex_seg(4'h0);
		end else begin
			score  <= score_nxt;
			misses <= misses_nxt;
			// Score on the four low digits
			hex0   <= hex_seg(score_nxt[3:0]);
			hex1   <= hex_seg(score_nxt[7:4]);
			hex2   <= hex_seg(score_nxt[11:8]);
			hex3   <= hex_seg(score_nxt[15:12]);
			// Low miss byte on the upper two
			hex4   <= hex_seg(misses_nxt[3:0]);
			hex5   <= hex_seg(misses_nxt[7:4]);
		end
	end

endmodule
